/* list.f */
src/dbg_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/debug_unit.sv
src/mini_core.sv
src/debug_top.sv
testbench/tb_debug_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the Verilator model, run it into sim.log and judge the log
rm -rf obj_dir sim.log
verilator --binary -Wno-fatal --top-module tb_debug_top -f list.f -o tb_debug_top \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_debug_top > sim.log 2>&1
grep -q "Checks failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation ended early, see sim.log"; exit 1; }
echo "Simulation passed"

/* testbench/tb_debug_top.sv */
`timescale 1ns/1ps

module tb_debug_top;

    localparam int CLKS_PER_BIT = 8;
    localparam int IM_BYTES     = 64;
    localparam int RB_DEPTH     = 8;
    localparam int DM_BYTES     = 16;
    localparam int IM_WORDS     = IM_BYTES / 4;
    localparam int DUMP_BYTES   = 4 + DM_BYTES + 4 * RB_DEPTH;
    localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
    // Twelve commands, the program bytes and the quiet wait of four frames
    localparam int SENT_FRAMES  = 12 + IM_BYTES + 4;
    localparam int RECV_FRAMES  = 4 + DM_BYTES + 4 * DUMP_BYTES + 4 * RB_DEPTH + DM_BYTES + 4;
    localparam int CYCLE_LIMIT  = 2 * FRAME_CLKS * (SENT_FRAMES + RECV_FRAMES) + 1000;

    logic i_clock;
    logic i_reset;
    logic i_rx;
    logic o_tx;
    logic o_halted;

    int              cycle_cnt = 0;
    logic [31:0]     lcg_state = 32'h65f8_e6f2;
    dbg_pkg::byte_t  rx_q [$];    // Bytes seen on o_tx
    dbg_pkg::instr_t prog [IM_WORDS];
    dbg_pkg::word_t  exp_pc;
    dbg_pkg::word_t  exp_rb [RB_DEPTH];
    dbg_pkg::byte_t  exp_dm [DM_BYTES];
    logic            exp_halted;

    debug_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .IM_BYTES    (IM_BYTES),
        .RB_DEPTH    (RB_DEPTH),
        .DM_BYTES    (DM_BYTES)
    ) dut_i (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .o_tx    (o_tx),
        .o_halted(o_halted)
    );

    initial begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    task automatic stop_with_error();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge i_clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
            stop_with_error();
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Fixed op sequence, random registers and immediates
    task automatic build_program();
        dbg_pkg::opcode_t kinds [IM_WORDS];
        logic [31:0]      r;
        kinds = '{dbg_pkg::OP_ADDI, dbg_pkg::OP_ADDI, dbg_pkg::OP_SB,   dbg_pkg::OP_ADD,
                  dbg_pkg::OP_LB,   dbg_pkg::OP_SUB,  dbg_pkg::OP_ADDI, dbg_pkg::OP_SB,
                  dbg_pkg::OP_LB,   dbg_pkg::OP_ADD,  dbg_pkg::OP_SB,   dbg_pkg::OP_SUB,
                  dbg_pkg::OP_LB,   dbg_pkg::OP_ADDI, dbg_pkg::OP_LB,   dbg_pkg::OP_HALT};
        for (int w = 0; w < IM_WORDS; w++) begin
            r       = lcg_next();
            prog[w] = '0;
            if (kinds[w] == dbg_pkg::OP_ADD || kinds[w] == dbg_pkg::OP_SUB) begin
                prog[w].alu_view.op = kinds[w];
                prog[w].alu_view.rd = r[31:29];
                prog[w].alu_view.rs = r[28:26];
                prog[w].alu_view.rt = r[25:23];
            end else begin
                prog[w].imm_view.op  = kinds[w];
                prog[w].imm_view.rd  = r[31:29];
                prog[w].imm_view.rs  = r[28:26];
                prog[w].imm_view.imm = r[25:10];
            end
        end
    endtask

    // Reference interpreter, leaves the state after count instructions in exp_*
    function automatic void run_model(input int count);
        dbg_pkg::instr_t ins;
        dbg_pkg::word_t  pc;
        dbg_pkg::word_t  src;
        dbg_pkg::word_t  imm;
        dbg_pkg::word_t  addr;
        dbg_pkg::word_t  result;
        logic            write_rd;
        pc         = '0;
        exp_halted = 1'b0;
        for (int i = 0; i < RB_DEPTH; i++) begin
            exp_rb[i] = '0;
        end
        for (int i = 0; i < DM_BYTES; i++) begin
            exp_dm[i] = '0;
        end
        for (int n = 0; n < count && !exp_halted; n++) begin
            ins      = prog[pc];
            src      = exp_rb[ins.alu_view.rs];
            imm      = int'(ins.imm_view.imm);    // Sign extended
            addr     = (src + imm) % DM_BYTES;
            result   = '0;
            write_rd = 1'b1;
            case (ins.alu_view.op)
                dbg_pkg::OP_ADD:  result = src + exp_rb[ins.alu_view.rt];
                dbg_pkg::OP_SUB:  result = src - exp_rb[ins.alu_view.rt];
                dbg_pkg::OP_ADDI: result = src + imm;
                dbg_pkg::OP_LB:   result = {24'd0, exp_dm[addr]};
                dbg_pkg::OP_SB: begin
                    write_rd     = 1'b0;
                    exp_dm[addr] = exp_rb[ins.imm_view.rd][7:0];
                end
                dbg_pkg::OP_HALT: begin
                    write_rd   = 1'b0;
                    exp_halted = 1'b1;
                end
                default: write_rd = 1'b0;
            endcase
            if (write_rd && ins.alu_view.rd != 3'd0) begin
                exp_rb[ins.alu_view.rd] = result;
            end
            if (!exp_halted) begin
                pc = (pc + 1) % IM_WORDS;
            end
        end
        exp_pc = pc;
    endfunction

    // One 8N1 frame on i_rx, LSB first
    task automatic send_byte(input dbg_pkg::byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        @(posedge i_clock);
        #1;
        for (int b = 0; b < 10; b++) begin
            i_rx = frame[b];
            repeat (CLKS_PER_BIT) @(posedge i_clock);
            #1;
        end
    endtask

    task automatic load_program();
        dbg_pkg::word_t w;
        send_byte(dbg_pkg::CMD_WRITE_IM);
        for (int i = 0; i < IM_WORDS; i++) begin
            w = prog[i];
            for (int b = 3; b >= 0; b--) begin
                send_byte(w[8*b +: 8]);    // Big endian
            end
        end
    endtask

    // Host receiver samples o_tx mid-bit on the falling edge
    initial begin : tx_monitor
        dbg_pkg::byte_t data;
        forever begin
            @(negedge i_clock);
            if (o_tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge i_clock);
                for (int b = 0; b < 8; b++) begin
                    repeat (CLKS_PER_BIT) @(negedge i_clock);
                    data[b] = o_tx;
                end
                repeat (CLKS_PER_BIT) @(negedge i_clock);
                if (o_tx !== 1'b1) begin
                    $display("Frame on o_tx ending at %0t has a low stop bit", $time);
                    stop_with_error();
                end
                rx_q.push_back(data);
            end
        end
    end

    task automatic pop_byte(output dbg_pkg::byte_t data);
        while (rx_q.size() == 0) begin
            @(posedge i_clock);
        end
        data = rx_q.pop_front();
    endtask

    task automatic check_byte(input string name, input dbg_pkg::byte_t expected);
        dbg_pkg::byte_t got;
        pop_byte(got);
        if (got !== expected) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, got);
            stop_with_error();
        end
    endtask

    task automatic check_word(input string name, input dbg_pkg::word_t expected);
        dbg_pkg::word_t got;
        dbg_pkg::byte_t b;
        got = '0;
        for (int i = 0; i < 4; i++) begin
            pop_byte(b);
            got = {got[23:0], b};    // MSB arrives first
        end
        if (got !== expected) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, got);
            stop_with_error();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic got);
        if (got !== expected) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, expected, got);
            stop_with_error();
        end
    endtask

    task automatic check_mem();
        for (int i = 0; i < DM_BYTES; i++) begin
            check_byte($sformatf("dm[%0d]", i), exp_dm[i]);
        end
    endtask

    task automatic check_regs();
        for (int i = 0; i < RB_DEPTH; i++) begin
            check_word($sformatf("r%0d", i), exp_rb[i]);
        end
    endtask

    task automatic check_dump();
        check_word("pc", exp_pc);
        check_mem();
        check_regs();
    endtask

    initial begin : scenario
        i_reset = 1'b1;
        i_rx    = 1'b1;    // Line idles high
        build_program();
        repeat (3) @(posedge i_clock);
        #1;
        i_reset = 1'b0;

        // Fresh state after reset
        run_model(0);
        send_byte(dbg_pkg::CMD_SEND_PC);
        check_word("pc", exp_pc);
        send_byte(dbg_pkg::CMD_SEND_MEM);
        check_mem();

        load_program();
        send_byte(dbg_pkg::CMD_STEP_BY_STEP);
        for (int n = 1; n <= 3; n++) begin
            send_byte(dbg_pkg::CMD_STEP);
            run_model(n);
            check_dump();
            check_flag("o_halted", exp_halted, o_halted);    // Not yet at HALT
        end

        // Run on to HALT
        send_byte(dbg_pkg::CMD_CONTINUE);
        run_model(4 * IM_WORDS);
        check_dump();
        check_flag("o_halted", exp_halted, o_halted);

        send_byte(dbg_pkg::CMD_SEND_BR);
        check_regs();
        send_byte(dbg_pkg::CMD_SEND_MEM);
        check_mem();

        // Unknown byte must stay silent
        send_byte(8'ha5);
        repeat (4 * FRAME_CLKS) @(posedge i_clock);
        if (rx_q.size() != 0) begin
            $display("Unknown command byte produced %0d transmitted bytes", rx_q.size());
            stop_with_error();
        end
        send_byte(dbg_pkg::CMD_SEND_PC);
        check_word("pc", exp_pc);

        $display("All checks passed");
        $finish;
    end

endmodule

/* src/debug_top.sv */
`timescale 1ns/1ps

module debug_top #(
    parameter int CLKS_PER_BIT = 87,    // 10 MHz clock, 115200 baud
    parameter int IM_BYTES     = 64,
    parameter int RB_DEPTH     = 8,
    parameter int DM_BYTES     = 16
) (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_rx,
    output logic o_tx,
    output logic o_halted
);

    logic                        rx_done;
    dbg_pkg::byte_t              rx_data;
    logic                        tx_start;
    dbg_pkg::byte_t              tx_data;
    logic                        tx_done;
    logic                        im_we;
    logic [$clog2(IM_BYTES)-1:0] im_addr;
    dbg_pkg::byte_t              im_data;
    logic [$clog2(RB_DEPTH)-1:0] rb_addr;
    dbg_pkg::word_t              rb_data;
    logic [$clog2(DM_BYTES)-1:0] dm_addr;
    dbg_pkg::byte_t              dm_data;
    dbg_pkg::word_t              pc;
    logic                        run;
    logic                        step;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_rx     (i_rx),
        .o_rx_done(rx_done),
        .o_rx_data(rx_data)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_tx_start(tx_start),
        .i_tx_data (tx_data),
        .o_tx      (o_tx),
        .o_tx_done (tx_done)
    );

    debug_unit #(
        .IM_BYTES(IM_BYTES),
        .RB_DEPTH(RB_DEPTH),
        .DM_BYTES(DM_BYTES)
    ) debug_unit_i (
        .i_clock   (i_clock),   .i_reset  (i_reset),
        .i_rx_done (rx_done),   .i_rx_data(rx_data),   .i_tx_done(tx_done),
        .i_pc      (pc),        .i_rb_data(rb_data),   .i_dm_data(dm_data),
        .i_halted  (o_halted),
        .o_tx_start(tx_start),  .o_tx_data(tx_data),
        .o_im_we   (im_we),     .o_im_addr(im_addr),   .o_im_data(im_data),
        .o_rb_addr (rb_addr),   .o_dm_addr(dm_addr),
        .o_run     (run),       .o_step   (step)
    );

    mini_core #(
        .IM_BYTES(IM_BYTES),
        .RB_DEPTH(RB_DEPTH),
        .DM_BYTES(DM_BYTES)
    ) mini_core_i (
        .i_clock  (i_clock),    .i_reset  (i_reset),
        .i_im_we  (im_we),      .i_im_addr(im_addr),   .i_im_data(im_data),
        .i_run    (run),        .i_step   (step),
        .i_rb_addr(rb_addr),    .i_dm_addr(dm_addr),
        .o_pc     (pc),         .o_rb_data(rb_data),   .o_dm_data(dm_data),
        .o_halted (o_halted)
    );

endmodule

/* src/mini_core.sv */
`timescale 1ns/1ps

module mini_core #(
    parameter int IM_BYTES = 64,
    parameter int RB_DEPTH = 8,
    parameter int DM_BYTES = 16
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_im_we,
    input  logic [$clog2(IM_BYTES)-1:0] i_im_addr,
    input  dbg_pkg::byte_t              i_im_data,
    input  logic                        i_run,
    input  logic                        i_step,
    input  logic [$clog2(RB_DEPTH)-1:0] i_rb_addr,
    input  logic [$clog2(DM_BYTES)-1:0] i_dm_addr,
    output dbg_pkg::word_t              o_pc,
    output dbg_pkg::word_t              o_rb_data,
    output dbg_pkg::byte_t              o_dm_data,
    output logic                        o_halted
);

    localparam int DM_AW = $clog2(DM_BYTES);
    localparam int PC_W  = $clog2(IM_BYTES) - 2;    // Word PC

    dbg_pkg::byte_t im [IM_BYTES];
    dbg_pkg::word_t rb [RB_DEPTH];
    dbg_pkg::byte_t dm [DM_BYTES];

    logic [PC_W-1:0]  pc_q;
    logic             halted_q;
    logic             exec;
    dbg_pkg::instr_t  instr;
    dbg_pkg::word_t   rs_val;
    dbg_pkg::word_t   rt_val;
    dbg_pkg::word_t   imm_ext;
    dbg_pkg::word_t   ea;
    logic [DM_AW-1:0] dm_ea;
    logic             rd_we;
    dbg_pkg::word_t   rd_val;

    // Big-endian word fetch
    assign instr = {im[{pc_q, 2'd0}], im[{pc_q, 2'd1}],
                    im[{pc_q, 2'd2}], im[{pc_q, 2'd3}]};

    assign exec    = (i_run || i_step) && !halted_q;
    assign rs_val  = rb[instr.alu_view.rs];
    assign rt_val  = rb[instr.alu_view.rt];
    assign imm_ext = {{16{instr.imm_view.imm[15]}}, instr.imm_view.imm};
    assign ea      = rs_val + imm_ext;
    assign dm_ea   = ea[DM_AW-1:0];    // Address wraps in data memory

    always_comb begin
        rd_we  = 1'b0;
        rd_val = ea;
        case (instr.alu_view.op)
            dbg_pkg::OP_ADD: begin
                rd_we  = 1'b1;
                rd_val = rs_val + rt_val;
            end
            dbg_pkg::OP_SUB: begin
                rd_we  = 1'b1;
                rd_val = rs_val - rt_val;
            end
            dbg_pkg::OP_ADDI: rd_we = 1'b1;
            dbg_pkg::OP_LB: begin
                rd_we  = 1'b1;
                rd_val = {24'd0, dm[dm_ea]};
            end
            default: rd_we = 1'b0;    // SB, HALT and unknown codes
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pc_q     <= '0;
            halted_q <= 1'b0;
            for (int i = 0; i < IM_BYTES; i++) begin
                im[i] <= '0;
            end
            for (int i = 0; i < RB_DEPTH; i++) begin
                rb[i] <= '0;
            end
            for (int i = 0; i < DM_BYTES; i++) begin
                dm[i] <= '0;
            end
        end else begin
            if (i_im_we) begin
                im[i_im_addr] <= i_im_data;
            end
            if (exec) begin
                // r0 is never written so it stays zero
                if (rd_we && instr.alu_view.rd != 3'd0) begin
                    rb[instr.alu_view.rd] <= rd_val;
                end
                if (instr.imm_view.op == dbg_pkg::OP_SB) begin
                    dm[dm_ea] <= rb[instr.imm_view.rd][7:0];
                end
                if (instr.alu_view.op == dbg_pkg::OP_HALT) begin
                    halted_q <= 1'b1;    // PC stays on the HALT
                end else begin
                    pc_q <= pc_q + 1'b1;
                end
            end
        end
    end

    assign o_pc      = {{(32 - PC_W){1'b0}}, pc_q};
    assign o_rb_data = rb[i_rb_addr];
    assign o_dm_data = dm[i_dm_addr];
    assign o_halted  = halted_q;

endmodule

/* src/debug_unit.sv */
`timescale 1ns/1ps

module debug_unit #(
    parameter int IM_BYTES = 64,
    parameter int RB_DEPTH = 8,
    parameter int DM_BYTES = 16
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_rx_done,
    input  dbg_pkg::byte_t              i_rx_data,
    input  logic                        i_tx_done,
    input  dbg_pkg::word_t              i_pc,
    input  dbg_pkg::word_t              i_rb_data,
    input  dbg_pkg::byte_t              i_dm_data,
    input  logic                        i_halted,
    output logic                        o_tx_start,
    output dbg_pkg::byte_t              o_tx_data,
    output logic                        o_im_we,
    output logic [$clog2(IM_BYTES)-1:0] o_im_addr,
    output dbg_pkg::byte_t              o_im_data,
    output logic [$clog2(RB_DEPTH)-1:0] o_rb_addr,
    output logic [$clog2(DM_BYTES)-1:0] o_dm_addr,
    output logic                        o_run,
    output logic                        o_step
);

    localparam int IM_AW = $clog2(IM_BYTES);
    localparam int RB_AW = $clog2(RB_DEPTH);
    localparam int DM_AW = $clog2(DM_BYTES);
    localparam logic [IM_AW-1:0] IM_LAST = IM_AW'(IM_BYTES - 1);
    localparam logic [RB_AW-1:0] RB_LAST = RB_AW'(RB_DEPTH - 1);
    localparam logic [DM_AW-1:0] DM_LAST = DM_AW'(DM_BYTES - 1);

    dbg_pkg::dbg_state_t state;
    logic [IM_AW-1:0]    load_cnt;
    logic [1:0]          byte_cnt;     // Byte within PC or register word
    logic [RB_AW-1:0]    rb_cnt;
    logic [DM_AW-1:0]    dm_cnt;
    logic                full_dump;    // PC, memory and registers back to back
    logic                back_to_step; // Dump ends in STEP_WAIT
    logic                step_cmd;
    dbg_pkg::word_t      word_sel;

    assign step_cmd = state == dbg_pkg::STEP_WAIT && i_rx_done
                      && i_rx_data == dbg_pkg::CMD_STEP;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state        <= dbg_pkg::IDLE;
            load_cnt     <= '0;
            byte_cnt     <= '0;
            rb_cnt       <= '0;
            dm_cnt       <= '0;
            full_dump    <= 1'b0;
            back_to_step <= 1'b0;
            o_tx_start   <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            case (state)
                dbg_pkg::IDLE: begin
                    if (i_rx_done) begin
                        full_dump    <= 1'b0;
                        back_to_step <= 1'b0;
                        case (i_rx_data)
                            dbg_pkg::CMD_WRITE_IM: begin
                                load_cnt <= '0;
                                state    <= dbg_pkg::LOAD_WAIT;
                            end
                            dbg_pkg::CMD_SEND_PC: begin
                                o_tx_start <= 1'b1;
                                state      <= dbg_pkg::SEND_PC;
                            end
                            dbg_pkg::CMD_SEND_MEM: begin
                                o_tx_start <= 1'b1;
                                state      <= dbg_pkg::SEND_MEM;
                            end
                            dbg_pkg::CMD_SEND_BR: begin
                                o_tx_start <= 1'b1;
                                state      <= dbg_pkg::SEND_BR;
                            end
                            default: state <= dbg_pkg::IDLE;
                        endcase
                    end
                end
                dbg_pkg::LOAD_WAIT: begin
                    if (i_rx_done) begin
                        o_im_data <= i_rx_data;
                        state     <= dbg_pkg::LOAD_WRITE;
                    end
                end
                dbg_pkg::LOAD_WRITE: begin
                    // Core writes the byte during this cycle
                    load_cnt <= load_cnt + 1'b1;
                    state    <= (load_cnt == IM_LAST) ? dbg_pkg::READY : dbg_pkg::LOAD_WAIT;
                end
                dbg_pkg::READY: begin
                    if (i_rx_done && i_rx_data == dbg_pkg::CMD_START) begin
                        state <= dbg_pkg::RUN;
                    end else if (i_rx_done && i_rx_data == dbg_pkg::CMD_STEP_BY_STEP) begin
                        state <= dbg_pkg::STEP_WAIT;
                    end
                end
                dbg_pkg::STEP_WAIT: begin
                    if (step_cmd) begin
                        full_dump    <= 1'b1;
                        back_to_step <= 1'b1;
                        o_tx_start   <= 1'b1;    // Core has already stepped
                        state        <= dbg_pkg::SEND_PC;
                    end else if (i_rx_done && i_rx_data == dbg_pkg::CMD_CONTINUE) begin
                        state <= dbg_pkg::RUN;
                    end
                end
                dbg_pkg::RUN: begin
                    if (i_halted) begin
                        full_dump    <= 1'b1;
                        back_to_step <= 1'b0;
                        o_tx_start   <= 1'b1;
                        state        <= dbg_pkg::SEND_PC;
                    end
                end
                dbg_pkg::SEND_PC: begin
                    if (i_tx_done) begin
                        byte_cnt   <= byte_cnt + 1'b1;    // Wraps back to 0
                        o_tx_start <= byte_cnt != 2'd3 || full_dump;
                        if (byte_cnt == 2'd3) begin
                            state <= full_dump ? dbg_pkg::SEND_MEM : dbg_pkg::IDLE;
                        end
                    end
                end
                dbg_pkg::SEND_MEM: begin
                    if (i_tx_done) begin
                        dm_cnt     <= (dm_cnt == DM_LAST) ? '0 : dm_cnt + 1'b1;
                        o_tx_start <= dm_cnt != DM_LAST || full_dump;
                        if (dm_cnt == DM_LAST) begin
                            state <= full_dump ? dbg_pkg::SEND_BR : dbg_pkg::IDLE;
                        end
                    end
                end
                dbg_pkg::SEND_BR: begin
                    if (i_tx_done) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            rb_cnt <= (rb_cnt == RB_LAST) ? '0 : rb_cnt + 1'b1;
                        end
                        if (byte_cnt == 2'd3 && rb_cnt == RB_LAST) begin
                            state <= back_to_step ? dbg_pkg::STEP_WAIT : dbg_pkg::IDLE;
                        end else begin
                            o_tx_start <= 1'b1;
                        end
                    end
                end
                default: state <= dbg_pkg::IDLE;
            endcase
        end
    end

    // Byte on the wire follows the counters
    always_comb begin
        word_sel = (state == dbg_pkg::SEND_PC) ? i_pc : i_rb_data;
        case (byte_cnt)
            2'd0:    o_tx_data = word_sel[31:24];    // MSB first
            2'd1:    o_tx_data = word_sel[23:16];
            2'd2:    o_tx_data = word_sel[15:8];
            default: o_tx_data = word_sel[7:0];
        endcase
        if (state == dbg_pkg::SEND_MEM) begin
            o_tx_data = i_dm_data;
        end
    end

    assign o_im_we   = state == dbg_pkg::LOAD_WRITE;
    assign o_im_addr = load_cnt;
    assign o_rb_addr = rb_cnt;
    assign o_dm_addr = dm_cnt;
    assign o_run     = state == dbg_pkg::RUN;
    assign o_step    = step_cmd;

endmodule

/* src/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 87
) (
    input  logic           i_clock,
    input  logic           i_reset,
    input  logic           i_tx_start,
    input  dbg_pkg::byte_t i_tx_data,
    output logic           o_tx,
    output logic           o_tx_done
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] PRE_LAST = CW'(CLKS_PER_BIT - 2);

    logic          busy;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_idx;
    logic [9:0]    frame;    // Stop, data, start

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            busy      <= 1'b0;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            o_tx_done <= 1'b0;
        end else begin
            // Strobe sits on the last cycle of the stop bit
            o_tx_done <= busy && bit_idx == 4'd9 && clk_cnt == PRE_LAST;
            if (!busy) begin
                if (i_tx_start) begin
                    busy    <= 1'b1;
                    frame   <= {1'b1, i_tx_data, 1'b0};
                    clk_cnt <= '0;
                    bit_idx <= '0;
                end
            end else if (clk_cnt == BIT_LAST) begin
                clk_cnt <= '0;
                frame   <= {1'b1, frame[9:1]};
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd9) begin
                    busy <= 1'b0;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    assign o_tx = busy ? frame[0] : 1'b1;

endmodule

/* src/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 87
) (
    input  logic           i_clock,
    input  logic           i_reset,
    input  logic           i_rx,
    output logic           o_rx_done,
    output dbg_pkg::byte_t o_rx_data
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CW-1:0] BIT_LAST  = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic           rx_meta;
    logic           rx_sync;
    logic [1:0]     state;
    logic [CW-1:0]  clk_cnt;
    logic [2:0]     bit_idx;
    dbg_pkg::byte_t shift;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            rx_meta   <= 1'b1;    // Idle level
            rx_sync   <= 1'b1;
            state     <= S_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            o_rx_done <= 1'b0;
        end else begin
            rx_meta   <= i_rx;
            rx_sync   <= rx_meta;
            o_rx_done <= 1'b0;
            clk_cnt   <= clk_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    // Recheck the line in the middle of the start bit
                    if (clk_cnt == HALF_LAST) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? S_IDLE : S_DATA;
                    end
                end
                S_DATA: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        shift   <= {rx_sync, shift[7:1]};    // LSB arrives first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end
                end
                default: begin
                    if (clk_cnt == BIT_LAST) begin
                        o_rx_done <= rx_sync;    // Low stop bit drops the frame
                        state     <= S_IDLE;
                    end
                end
            endcase
        end
    end

    assign o_rx_data = shift;

endmodule

/* src/dbg_pkg.sv */
package dbg_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    // Host command bytes
    localparam byte_t CMD_WRITE_IM     = 8'd1;
    localparam byte_t CMD_START        = 8'd2;
    localparam byte_t CMD_STEP_BY_STEP = 8'd3;
    localparam byte_t CMD_SEND_BR      = 8'd4;
    localparam byte_t CMD_SEND_MEM     = 8'd5;
    localparam byte_t CMD_SEND_PC      = 8'd6;
    localparam byte_t CMD_STEP         = 8'd7;
    localparam byte_t CMD_CONTINUE     = 8'd8;

    typedef enum logic [3:0] {
        IDLE,
        LOAD_WAIT,
        LOAD_WRITE,
        READY,
        RUN,
        STEP_WAIT,
        SEND_PC,
        SEND_MEM,
        SEND_BR
    } dbg_state_t;

    typedef logic [3:0] opcode_t;

    // Zero is left free so that a blank memory runs as no-ops
    localparam opcode_t OP_ADD  = 4'h1;
    localparam opcode_t OP_SUB  = 4'h2;
    localparam opcode_t OP_ADDI = 4'h3;
    localparam opcode_t OP_LB   = 4'h4;
    localparam opcode_t OP_SB   = 4'h5;
    localparam opcode_t OP_HALT = 4'hf;

    typedef union packed {
        struct packed {
            opcode_t     op;
            logic [2:0]  rd;
            logic [2:0]  rs;
            logic [2:0]  rt;
            logic [18:0] unused;
        } alu_view;    // ADD, SUB
        struct packed {
            opcode_t            op;
            logic [2:0]         rd;
            logic [2:0]         rs;
            logic signed [15:0] imm;
            logic [5:0]         unused;
        } imm_view;    // ADDI, LB, SB
    } instr_t;

endpackage
